// ==== source/coreTypes.sv ====
package coreTypes;

    localparam int dataWidth = 32;
    localparam int regCnt = 32;
    localparam int regWidth = 5;
    localparam int robDepth = 8;
    localparam int robIdxWidth = $clog2(robDepth);
    localparam int tagWidth = 4;
    localparam int numSlots = 4;
    localparam int immWidth = 16;

    typedef logic [dataWidth-1:0] data_t;
    typedef logic [regWidth-1:0]  reg_t;
    typedef logic [tagWidth-1:0]  tag_t;    // rob entry index plus one.
    typedef logic [immWidth-1:0]  imm_t;

    // zero means the value is present.
    localparam tag_t tagFree = '0;

    typedef enum logic [2:0] {
        ADD = 3'd0,
        SUB = 3'd1,
        AND = 3'd2,
        OR  = 3'd3,
        XOR = 3'd4,
        LDI = 3'd5
    } op_t;

    typedef enum logic [1:0] {
        FREE = 2'd0,
        WAIT = 2'd1,    // operands outstanding.
        DONE = 2'd2
    } slotState_t;

endpackage

// ==== source/coreIfs.sv ====
interface issueBus import coreTypes::*; ();
    logic [numSlots-1:0] load;    // one-hot slot select.
    op_t   op;
    tag_t  tag1;
    data_t val1;
    tag_t  tag2;
    data_t val2;
    tag_t  destTag;

    modport src (output load, op, tag1, val1, tag2, val2, destTag);
    modport sink (input load, op, tag1, val1, tag2, val2, destTag);
endinterface

// operand lookup into the reorder buffer.
interface robLookup import coreTypes::*; ();
    tag_t  qTag1;
    tag_t  qTag2;
    logic  hit1;
    data_t hitVal1;
    logic  hit2;
    data_t hitVal2;

    modport src (output qTag1, qTag2, input hit1, hitVal1, hit2, hitVal2);
    modport sink (input qTag1, qTag2, output hit1, hitVal1, hit2, hitVal2);
endinterface

// ==== source/regFile.sv ====
module regFile import coreTypes::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  enWrite,
    input  reg_t  namew,
    input  data_t dataw,
    input  tag_t  tagw,
    input  logic  enRename,
    input  reg_t  nameRename,
    input  tag_t  tagRename,
    input  reg_t  name1,
    output tag_t  tag1,
    output data_t data1,
    input  reg_t  name2,
    output tag_t  tag2,
    output data_t data2,
    input  reg_t  name3,
    output tag_t  tag3,
    output data_t data3
);
    data_t dataArr [regCnt];
    tag_t  tagArr [regCnt];

    // reads see the commit that is in flight.
    function automatic data_t readData(reg_t name);
        if (name == '0) begin
            return '0;
        end
        if (enWrite && name == namew) begin
            return dataw;
        end
        return dataArr[name];
    endfunction

    function automatic tag_t readTag(reg_t name);
        if (name == '0) begin
            return tagFree;
        end
        if (enWrite && name == namew && tagArr[name] == tagw) begin
            return tagFree;
        end
        return tagArr[name];
    endfunction

    always_comb begin
        data1 = readData(name1);
        tag1  = readTag(name1);
        data2 = readData(name2);
        tag2  = readTag(name2);
        data3 = readData(name3);
        tag3  = readTag(name3);
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < regCnt; i++) begin
                tagArr[i] <= tagFree;
            end
        end else begin
            // only the newest producer may clear the tag.
            if (enWrite && namew != '0 && tagArr[namew] == tagw) begin
                tagArr[namew] <= tagFree;
            end
            if (enRename && nameRename != '0) begin
                tagArr[nameRename] <= tagRename;    // rename wins.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (enWrite && namew != '0) begin
            dataArr[namew] <= dataw;
        end
    end

    renameTagValid: assert property (@(posedge clk) disable iff (rst)
        enRename |-> tagRename != tagFree);

endmodule

// ==== source/dispatchUnit.sv ====
module dispatchUnit import coreTypes::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                instValid,
    input  op_t                 instOp,
    input  reg_t                instRd,
    input  reg_t                instRs1,
    input  reg_t                instRs2,
    input  imm_t                instImm,
    output logic                instReady,
    output reg_t                rfName1,
    output reg_t                rfName2,
    input  tag_t                rfTag1,
    input  tag_t                rfTag2,
    input  data_t               rfData1,
    input  data_t               rfData2,
    output logic                enRename,
    output reg_t                nameRename,
    output tag_t                tagRename,
    issueBus.src                iss,
    robLookup.src               rob,
    input  logic [numSlots-1:0] slotFree,
    input  logic                robFull,
    input  tag_t                allocTag,
    output logic                alloc
);
    logic                accept;
    logic [numSlots-1:0] pick;

    assign instReady = |slotFree && !robFull;
    assign accept = instValid && instReady;
    assign alloc = accept;

    assign pick = slotFree & (~slotFree + 1'b1);    // lowest free slot.

    assign rfName1 = instRs1;
    assign rfName2 = instRs2;

    // pending producers may already sit in the rob.
    assign rob.qTag1 = rfTag1;
    assign rob.qTag2 = rfTag2;

    assign enRename = accept && instRd != '0;
    assign nameRename = instRd;
    assign tagRename = allocTag;

    always_comb begin
        iss.load = accept ? pick : '0;
        iss.op = instOp;
        iss.destTag = allocTag;
        if (instOp == LDI) begin
            iss.tag1 = tagFree;
            iss.val1 = data_t'(instImm);    // zero extended.
            iss.tag2 = tagFree;
            iss.val2 = '0;
        end else begin
            iss.tag1 = (rfTag1 == tagFree || rob.hit1) ? tagFree : rfTag1;
            iss.val1 = (rfTag1 == tagFree) ? rfData1 : rob.hitVal1;
            iss.tag2 = (rfTag2 == tagFree || rob.hit2) ? tagFree : rfTag2;
            iss.val2 = (rfTag2 == tagFree) ? rfData2 : rob.hitVal2;
        end
    end

    // an operand never waits on the entry being allocated.
    noSelfWait: assert property (@(posedge clk) disable iff (rst)
        accept |-> iss.tag1 != iss.destTag && iss.tag2 != iss.destTag);

endmodule

// ==== source/execSlot.sv ====
module execSlot import coreTypes::*; #(
    parameter int index = 0
) (
    input  logic  clk,
    input  logic  rst,
    issueBus.sink iss,
    input  logic  cdbValid,
    input  tag_t  cdbTag,
    input  data_t cdbData,
    output logic  free,
    output logic  req,
    output tag_t  resTag,
    output data_t resData,
    input  logic  grant
);
    slotState_t state;
    op_t        op;
    tag_t       tag1;
    tag_t       tag2;
    data_t      val1;
    data_t      val2;
    tag_t       destTag;
    data_t      result;
    logic       load;
    logic       ready;

    assign load = iss.load[index];
    assign ready = tag1 == tagFree && tag2 == tagFree;

    assign free = state == FREE;
    assign req = state == DONE;    // held until granted.
    assign resTag = destTag;
    assign resData = result;

    function automatic data_t alu(op_t f, data_t a, data_t b);
        case (f)
            ADD:     return a + b;
            SUB:     return a - b;
            AND:     return a & b;
            OR:      return a | b;
            XOR:     return a ^ b;
            default: return a;    // ldi passes val1.
        endcase
    endfunction

    function automatic logic snoop(tag_t t);
        return cdbValid && t != tagFree && cdbTag == t;
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= FREE;
        end else begin
            case (state)
                FREE:    if (load) state <= WAIT;
                WAIT:    if (ready) state <= DONE;
                DONE:    if (grant) state <= FREE;
                default: state <= FREE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == FREE && load) begin
            op <= iss.op;
            destTag <= iss.destTag;
            tag1 <= snoop(iss.tag1) ? tagFree : iss.tag1;
            val1 <= snoop(iss.tag1) ? cdbData : iss.val1;
            tag2 <= snoop(iss.tag2) ? tagFree : iss.tag2;
            val2 <= snoop(iss.tag2) ? cdbData : iss.val2;
        end else if (state == WAIT) begin
            if (snoop(tag1)) begin
                tag1 <= tagFree;
                val1 <= cdbData;
            end
            if (snoop(tag2)) begin
                tag2 <= tagFree;
                val2 <= cdbData;
            end
            if (ready) begin
                result <= alu(op, val1, val2);
            end
        end
    end

endmodule

// ==== source/commitUnit.sv ====
module commitUnit import coreTypes::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic [numSlots-1:0] req,
    input  tag_t                resTag [numSlots],
    input  data_t               resData [numSlots],
    output logic [numSlots-1:0] grant,
    output logic                cdbValid,
    output tag_t                cdbTag,
    output data_t               cdbData,
    input  logic                alloc,
    input  reg_t                allocRd,
    output tag_t                allocTag,
    output logic                robFull,
    robLookup.sink              lk,
    output logic                enWrite,
    output reg_t                namew,
    output data_t               dataw,
    output tag_t                tagw,
    output logic                commitValid,
    output reg_t                commitName,
    output data_t               commitData
);
    logic [robIdxWidth-1:0] head;
    logic [robIdxWidth-1:0] tail;
    logic [robIdxWidth-1:0] cdbIdx;
    logic [robIdxWidth:0]   count;
    logic [robDepth-1:0]    done;
    reg_t                   dest [robDepth];
    data_t                  value [robDepth];
    logic                   retire;

    function automatic logic [robIdxWidth-1:0] tagToIdx(tag_t t);
        return robIdxWidth'(t - tag_t'(1));
    endfunction

    // fixed priority, slot 0 first.
    assign grant = req & (~req + 1'b1);
    assign cdbValid = |req;

    always_comb begin
        cdbTag = tagFree;
        cdbData = '0;
        for (int i = 0; i < numSlots; i++) begin
            if (grant[i]) begin
                cdbTag = resTag[i];
                cdbData = resData[i];
            end
        end
    end

    assign cdbIdx = tagToIdx(cdbTag);
    assign robFull = count == robDepth;
    assign allocTag = tag_t'(tail) + tag_t'(1);

    assign lk.hit1 = lk.qTag1 != tagFree && done[tagToIdx(lk.qTag1)];
    assign lk.hitVal1 = value[tagToIdx(lk.qTag1)];
    assign lk.hit2 = lk.qTag2 != tagFree && done[tagToIdx(lk.qTag2)];
    assign lk.hitVal2 = value[tagToIdx(lk.qTag2)];

    assign retire = count != '0 && done[head];
    assign enWrite = retire;
    assign namew = dest[head];
    assign dataw = value[head];
    assign tagw = tag_t'(head) + tag_t'(1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head <= '0;
            tail <= '0;
            count <= '0;
            done <= '0;
            commitValid <= 1'b0;
        end else begin
            if (alloc) begin
                tail <= tail + 1'b1;    // wraps at robDepth.
                done[tail] <= 1'b0;
            end
            if (cdbValid) begin
                done[cdbIdx] <= 1'b1;
            end
            if (retire) begin
                head <= head + 1'b1;
                done[head] <= 1'b0;
            end
            count <= count + {{robIdxWidth{1'b0}}, alloc} - {{robIdxWidth{1'b0}}, retire};
            commitValid <= retire;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            dest[tail] <= allocRd;
        end
        if (cdbValid) begin
            value[cdbIdx] <= cdbData;
        end
        if (retire) begin
            commitName <= dest[head];
            commitData <= value[head];
        end
    end

    // a request that lost arbitration is still raised next cycle.
    reqHeldUntilGrant: assert property (@(posedge clk) disable iff (rst)
        (req & ~grant) != '0 |=> (req & $past(req & ~grant)) == $past(req & ~grant));

    // a slot result lands on a live entry that has no result yet.
    cdbHitsOpenEntry: assert property (@(posedge clk) disable iff (rst)
        cdbValid |-> count != '0 && !done[cdbIdx]);

endmodule

// ==== source/oooCore.sv ====
module oooCore import coreTypes::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  instValid,
    input  op_t   instOp,
    input  reg_t  instRd,
    input  reg_t  instRs1,
    input  reg_t  instRs2,
    input  imm_t  instImm,
    output logic  instReady,
    output logic  commitValid,
    output reg_t  commitName,
    output data_t commitData,
    input  reg_t  peekName,
    output data_t peekData,
    output tag_t  peekTag
);
    issueBus  iss ();
    robLookup lk ();

    reg_t  rfName1;
    reg_t  rfName2;
    tag_t  rfTag1;
    tag_t  rfTag2;
    data_t rfData1;
    data_t rfData2;
    logic  enRename;
    reg_t  nameRename;
    tag_t  tagRename;
    logic  enWrite;
    reg_t  namew;
    data_t dataw;
    tag_t  tagw;
    logic  alloc;
    tag_t  allocTag;
    logic  robFull;
    logic  cdbValid;
    tag_t  cdbTag;
    data_t cdbData;

    logic [numSlots-1:0] slotFree;
    logic [numSlots-1:0] slotReq;
    logic [numSlots-1:0] grant;
    tag_t                resTag [numSlots];
    data_t               resData [numSlots];

    regFile i_regFile (
        .clk, .rst, .enWrite, .namew, .dataw, .tagw,
        .enRename, .nameRename, .tagRename,
        .name1(rfName1), .tag1(rfTag1), .data1(rfData1),
        .name2(rfName2), .tag2(rfTag2), .data2(rfData2),
        .name3(peekName), .tag3(peekTag), .data3(peekData)    // peek port.
    );

    dispatchUnit i_dispatch (
        .clk, .rst, .instValid, .instOp, .instRd, .instRs1, .instRs2, .instImm,
        .instReady, .rfName1, .rfName2, .rfTag1, .rfTag2, .rfData1, .rfData2,
        .enRename, .nameRename, .tagRename, .iss(iss.src), .rob(lk.src),
        .slotFree, .robFull, .allocTag, .alloc
    );

    for (genvar i = 0; i < numSlots; i++) begin : g_slot
        execSlot #(.index(i)) i_slot (
            .clk, .rst, .iss(iss.sink), .cdbValid, .cdbTag, .cdbData,
            .free(slotFree[i]), .req(slotReq[i]), .resTag(resTag[i]),
            .resData(resData[i]), .grant(grant[i])
        );
    end

    commitUnit i_commit (
        .clk, .rst, .req(slotReq), .resTag, .resData, .grant,
        .cdbValid, .cdbTag, .cdbData, .alloc, .allocRd(instRd), .allocTag, .robFull,
        .lk(lk.sink), .enWrite, .namew, .dataw, .tagw,
        .commitValid, .commitName, .commitData
    );

endmodule

// ==== tests/coreTb.sv ====
module coreTb import coreTypes::*; ();
    localparam int period = 40;
    localparam int maxInst = 32;

    logic  clk;
    logic  rst;
    logic  instValid;
    op_t   instOp;
    reg_t  instRd;
    reg_t  instRs1;
    reg_t  instRs2;
    imm_t  instImm;
    logic  instReady;
    logic  commitValid;
    reg_t  commitName;
    data_t commitData;
    reg_t  peekName;
    data_t peekData;
    tag_t  peekTag;

    logic [31:0] testMem [0:6*maxInst];    // count, then six words per instruction.
    int          numInst;
    int          cycleLimit = 1000;
    int          cycles = 0;
    int          seed;
    reg_t        expName [$];
    data_t       expData [$];
    data_t       modelRegs [regCnt];
    logic        touched [regCnt];

    oooCore i_dut (
        .clk, .rst, .instValid, .instOp, .instRd, .instRs1, .instRs2, .instImm,
        .instReady, .commitValid, .commitName, .commitData,
        .peekName, .peekData, .peekTag
    );

    initial begin
        clk = 1'b0;
        forever #(period/2) clk = ~clk;
    end

    task automatic stopRun();
        $display("CHECKS FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic checkEqual(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s, got %h, expected %h", $time, what, actual, expected);
            stopRun();
        end
    endtask

    // sequential reference for one instruction.
    function automatic data_t modelResult(op_t op, data_t a, data_t b, imm_t imm);
        case (op)
            ADD:     return a + b;
            SUB:     return a - b;
            AND:     return a & b;
            OR:      return a | b;
            XOR:     return a ^ b;
            LDI:     return {{(dataWidth-immWidth){1'b0}}, imm};
            default: return 'x;
        endcase
    endfunction

    task automatic loadTests();
        int    base;
        op_t   op;
        data_t res;
        $readmemh("tests/coreTests.txt", testMem);
        numInst = int'(testMem[0]);
        if (numInst < 1 || numInst > maxInst) begin
            $display("test file is missing or holds a bad instruction count");
            stopRun();
        end
        cycleLimit = 20 * numInst + 100;
        for (int r = 0; r < regCnt; r++) begin
            modelRegs[r] = '0;
            touched[r] = 1'b0;
        end
        for (int i = 0; i < numInst; i++) begin
            base = 1 + 6 * i;
            op = op_t'(testMem[base][2:0]);
            res = modelResult(op, modelRegs[reg_t'(testMem[base+2])],
                              modelRegs[reg_t'(testMem[base+3])], imm_t'(testMem[base+4]));
            checkEqual(res, testMem[base+5], $sformatf("model vs file, instruction %0d", i));
            expName.push_back(reg_t'(testMem[base+1]));
            expData.push_back(testMem[base+5]);
            touched[reg_t'(testMem[base+1])] = 1'b1;
            if (reg_t'(testMem[base+1]) != '0) begin
                modelRegs[reg_t'(testMem[base+1])] = res;
            end
        end
    endtask

    task automatic issueInst(input int i);
        int base;
        base = 1 + 6 * i;
        while (!instReady) @(negedge clk);    // back-pressure.
        instOp = op_t'(testMem[base][2:0]);
        instRd = reg_t'(testMem[base+1]);
        instRs1 = reg_t'(testMem[base+2]);
        instRs2 = reg_t'(testMem[base+3]);
        instImm = imm_t'(testMem[base+4]);
        instValid = 1'b1;
        @(negedge clk);
        instValid = 1'b0;
    endtask

    task automatic checkRegs();
        for (int r = 0; r < regCnt; r++) begin
            if (touched[r]) begin
                peekName = reg_t'(r);
                @(negedge clk);
                checkEqual(peekData, modelRegs[r], $sformatf("peek data r%0d", r));
                checkEqual(32'(peekTag), 32'(tagFree), $sformatf("peek tag r%0d", r));
            end
        end
    endtask

    // commits are sampled away from the clock edge.
    always @(negedge clk) begin
        if (!rst && commitValid) begin
            if (expData.size() == 0) begin
                $display("a commit came out with no instruction outstanding at %0t", $time);
                stopRun();
            end else begin
                checkEqual(32'(commitName), 32'(expName[0]), "commit register");
                checkEqual(commitData, expData[0], "commit data");
                void'(expName.pop_front());
                void'(expData.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycleLimit) begin
            $display("timeout: commits stopped, %0d still outstanding", expData.size());
            stopRun();
        end
    end

    initial begin
        int gap;
        seed = 97646;
        rst = 1'b1;
        instValid = 1'b0;
        instOp = ADD;
        instRd = '0;
        instRs1 = '0;
        instRs2 = '0;
        instImm = '0;
        peekName = '0;
        loadTests();
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        checkEqual(32'(instReady), 32'd1, "instReady after reset");
        checkEqual(32'(commitValid), 32'd0, "commitValid after reset");
        for (int i = 0; i < numInst; i++) begin
            issueInst(i);
            gap = int'($unsigned($random(seed)) % 3);
            repeat (gap) @(negedge clk);
        end
        while (expData.size() != 0) @(negedge clk);
        checkRegs();
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// ==== tests/coreTests.txt ====
// first word: instruction count. then one instruction per line, all hex.
// columns: op rd rs1 rs2 imm expected (op 0 add, 1 sub, 2 and, 3 or, 4 xor, 5 ldi)
18
// immediates.
5 01 00 00 1234 00001234
5 02 00 00 00ff 000000ff
// read-after-write chain.
0 03 01 02 0000 00001333
1 04 03 02 0000 00001234
4 05 04 03 0000 00000107
2 06 05 03 0000 00000103
3 07 06 01 0000 00001337
// two writes to r8, then a read.
5 08 00 00 aaaa 0000aaaa
5 08 00 00 5555 00005555
0 09 08 08 0000 0000aaaa
// register 0 commits but stays zero.
5 00 00 00 beef 0000beef
0 0a 00 01 0000 00001234
// independent work to fill slots and rob.
5 0b 00 00 0001 00000001
5 0c 00 00 0002 00000002
5 0d 00 00 0003 00000003
5 0e 00 00 0004 00000004
5 0f 00 00 0005 00000005
5 10 00 00 0006 00000006
4 11 01 02 0000 000012cb
3 12 02 08 0000 000055ff
0 13 0b 10 0000 00000007
1 14 0b 0c 0000 ffffffff
0 15 14 0f 0000 00000004
2 03 03 07 0000 00001333

// ==== sim.f ====
source/coreTypes.sv
source/coreIfs.sv
source/regFile.sv
source/dispatchUnit.sv
source/execSlot.sv
source/commitUnit.sv
source/oooCore.sv
tests/coreTb.sv

// ==== run.sh ====
#!/bin/sh
# build with verilator, run, then look for the pass line in the log.
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module coreTb -f sim.f -o coreSim \
    && ./obj_dir/coreSim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "ALL CHECKS PASSED" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
